// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;      // Data, address or instruction word
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;

    // Major opcode, instruction bits 6 to 2
    typedef enum logic [4:0] {
        LOAD   = 5'b00000,
        OP_IMM = 5'b00100,
        AUIPC  = 5'b00101,
        STORE  = 5'b01000,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        BRANCH = 5'b11000,
        JALR   = 5'b11001,
        JAL    = 5'b11011
    } opcode_e;

    // Branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // ALU functions
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam word_t RESET_PC    = 32'h0000_0000;
    localparam word_t NOP_INSTR   = 32'h0000_0013;  // ADDI x0,x0,0
    localparam word_t INSTR_BYTES = 32'd4;

endpackage

// ==== verilog/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          redirect_i,
    input  rv_pkg::word_t redirect_pc_i,
    output rv_pkg::word_t imem_addr_o,
    input  rv_pkg::word_t imem_rdata_i,
    output logic          if_valid_o,
    output rv_pkg::word_t if_pc_o,
    output rv_pkg::word_t if_instr_o
);
    import rv_pkg::*;

    word_t pc_q;

    assign imem_addr_o = pc_q;  // Memory answers in the same cycle

    // ------------------------------
    // PC and IF/ID register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q       <= RESET_PC;
            if_valid_o <= 1'b0;
            if_instr_o <= NOP_INSTR;
        end else begin
            pc_q       <= redirect_i ? redirect_pc_i : pc_q + INSTR_BYTES;  // Predict not taken
            if_valid_o <= !redirect_i;
            if_instr_o <= redirect_i ? NOP_INSTR : imem_rdata_i;  // Bubble on squash
        end
    end

    always_ff @(posedge clk) begin
        if_pc_o <= pc_q;
    end

endmodule

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    output rv_pkg::word_t     rs1_data_o,
    output rv_pkg::word_t     rs2_data_o,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t waddr_i,
    input  rv_pkg::word_t     wdata_i
);
    import rv_pkg::*;

    word_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle write is visible to the reader
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0)
            return '0;
        else if (we_i && waddr_i == addr)
            return wdata_i;
        else
            return regs[addr];
    endfunction

    assign rs1_data_o = read_port(rs1_i);
    assign rs2_data_o = read_port(rs2_i);

endmodule

// ==== verilog/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              if_valid_i,
    input  rv_pkg::word_t     if_pc_i,
    input  rv_pkg::word_t     if_instr_i,
    input  logic              flush_i,
    input  rv_pkg::word_t     rs1_data_i,
    input  rv_pkg::word_t     rs2_data_i,
    output rv_pkg::reg_addr_t rs1_o,
    output rv_pkg::reg_addr_t rs2_o,
    output logic              ex_valid_o,
    output rv_pkg::opcode_e   ex_opcode_o,
    output rv_pkg::funct3_t   ex_funct3_o,
    output logic              ex_alt_o,
    output rv_pkg::word_t     ex_pc_o,
    output rv_pkg::word_t     ex_imm_o,
    output rv_pkg::word_t     ex_rs1_val_o,
    output rv_pkg::word_t     ex_rs2_val_o,
    output rv_pkg::reg_addr_t ex_rd_o,
    output logic              ex_rd_we_o
);
    import rv_pkg::*;

    opcode_e   opcode;
    funct3_t   funct3;
    reg_addr_t rd;
    word_t     imm;
    logic      legal;
    logic      rd_we;
    logic      alt;

    assign opcode = opcode_e'(if_instr_i[6:2]);
    assign funct3 = if_instr_i[14:12];
    assign rd     = if_instr_i[11:7];
    assign rs1_o  = if_instr_i[19:15];  // Same field in every format
    assign rs2_o  = if_instr_i[24:20];

    // ------------------------------
    // Control and immediate
    // ------------------------------
    always_comb begin
        legal = (if_instr_i[1:0] == 2'b11);
        rd_we = 1'b0;
        alt   = 1'b0;
        imm   = {{20{if_instr_i[31]}}, if_instr_i[31:20]};  // I format by default
        case (opcode)
            LOAD, JALR: rd_we = 1'b1;
            OP_IMM: begin
                rd_we = 1'b1;
                alt   = (funct3 == F3_SR) && if_instr_i[30];  // SRAI
            end
            OP: begin
                rd_we = 1'b1;
                alt   = if_instr_i[30];  // SUB or SRA
            end
            LUI, AUIPC: begin
                rd_we = 1'b1;
                imm   = {if_instr_i[31:12], 12'b0};
            end
            STORE: imm = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
            BRANCH: begin
                imm = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                       if_instr_i[30:25], if_instr_i[11:8], 1'b0};
            end
            JAL: begin
                rd_we = 1'b1;
                imm   = {{11{if_instr_i[31]}}, if_instr_i[31], if_instr_i[19:12],
                         if_instr_i[20], if_instr_i[30:21], 1'b0};
            end
            default: legal = 1'b0;  // Runs as a no-op
        endcase
        if (rd == '0) begin
            rd_we = 1'b0;
        end
    end

    // ------------------------------
    // ID/EX register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ex_valid_o <= 1'b0;
        else
            ex_valid_o <= if_valid_i && legal && !flush_i;
    end

    always_ff @(posedge clk) begin
        ex_opcode_o  <= opcode;
        ex_funct3_o  <= funct3;
        ex_alt_o     <= alt;
        ex_pc_o      <= if_pc_i;
        ex_imm_o     <= imm;
        ex_rs1_val_o <= rs1_data_i;
        ex_rs2_val_o <= rs2_data_i;
        ex_rd_o      <= rd;
        ex_rd_we_o   <= rd_we;
    end

endmodule

// ==== verilog/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::word_t   a_i,
    input  rv_pkg::word_t   b_i,
    input  rv_pkg::funct3_t funct3_i,
    input  logic            alt_i,
    output rv_pkg::word_t   result_o,
    input  rv_pkg::funct3_t branch_funct3_i,
    output logic            take_o
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (funct3_i)
            F3_ADD:  result_o = alt_i ? a_i - b_i : a_i + b_i;
            F3_SLL:  result_o = a_i << shamt;
            F3_SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            F3_SLTU: result_o = {31'b0, a_i < b_i};
            F3_XOR:  result_o = a_i ^ b_i;
            F3_SR:   result_o = alt_i ? word_t'($signed(a_i) >>> shamt) : a_i >> shamt;
            F3_OR:   result_o = a_i | b_i;
            F3_AND:  result_o = a_i & b_i;
            default: result_o = '0;
        endcase
    end

    // Branch compare on rs1 and rs2
    always_comb begin
        case (branch_funct3_i)
            F3_BEQ:  take_o = (a_i == b_i);
            F3_BNE:  take_o = (a_i != b_i);
            F3_BLT:  take_o = $signed(a_i) < $signed(b_i);
            F3_BGE:  take_o = $signed(a_i) >= $signed(b_i);
            F3_BLTU: take_o = a_i < b_i;
            F3_BGEU: take_o = a_i >= b_i;
            default: take_o = 1'b0;  // Reserved codes
        endcase
    end

endmodule

// ==== verilog/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ex_valid_i,
    input  rv_pkg::opcode_e   ex_opcode_i,
    input  rv_pkg::funct3_t   ex_funct3_i,
    input  logic              ex_alt_i,
    input  rv_pkg::word_t     ex_pc_i,
    input  rv_pkg::word_t     ex_imm_i,
    input  rv_pkg::word_t     ex_rs1_val_i,
    input  rv_pkg::word_t     ex_rs2_val_i,
    input  rv_pkg::reg_addr_t ex_rd_i,
    input  logic              ex_rd_we_i,
    output logic              redirect_o,
    output rv_pkg::word_t     redirect_pc_o,
    output logic              ma_valid_o,
    output rv_pkg::opcode_e   ma_opcode_o,
    output rv_pkg::word_t     ma_result_o,
    output rv_pkg::word_t     ma_store_data_o,
    output rv_pkg::reg_addr_t ma_rd_o,
    output logic              ma_rd_we_o
);
    import rv_pkg::*;

    logic    is_mem;
    logic    take;
    funct3_t alu_funct3;
    word_t   alu_b;
    word_t   alu_result;
    word_t   pc_imm;
    word_t   jalr_sum;
    word_t   result;

    assign is_mem     = (ex_opcode_i == LOAD) || (ex_opcode_i == STORE);
    assign alu_b      = (is_mem || ex_opcode_i == OP_IMM) ? ex_imm_i : ex_rs2_val_i;
    assign alu_funct3 = is_mem ? F3_ADD : ex_funct3_i;  // Address add

    rv_alu u_alu (
        .a_i             (ex_rs1_val_i),
        .b_i             (alu_b),
        .funct3_i        (alu_funct3),
        .alt_i           (ex_alt_i),
        .result_o        (alu_result),
        .branch_funct3_i (ex_funct3_i),
        .take_o          (take)
    );

    // ------------------------------
    // Target and redirect
    // ------------------------------
    assign pc_imm        = ex_pc_i + ex_imm_i;  // Also the AUIPC result
    assign jalr_sum      = ex_rs1_val_i + ex_imm_i;
    assign redirect_pc_o = (ex_opcode_i == JALR) ? {jalr_sum[31:1], 1'b0} : pc_imm;
    assign redirect_o    = ex_valid_i && ((ex_opcode_i == BRANCH && take) ||
                                          ex_opcode_i == JAL || ex_opcode_i == JALR);

    always_comb begin
        case (ex_opcode_i)
            JAL, JALR: result = ex_pc_i + INSTR_BYTES;  // Link address
            LUI:       result = ex_imm_i;
            AUIPC:     result = pc_imm;
            default:   result = alu_result;
        endcase
    end

    // ------------------------------
    // EX/MA register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ma_valid_o <= 1'b0;
        else
            ma_valid_o <= ex_valid_i;
    end

    always_ff @(posedge clk) begin
        ma_opcode_o     <= ex_opcode_i;
        ma_result_o     <= result;
        ma_store_data_o <= ex_rs2_val_i;
        ma_rd_o         <= ex_rd_i;
        ma_rd_we_o      <= ex_rd_we_i;
    end

endmodule

// ==== verilog/rv_mem_wb.sv ====
`timescale 1ns/1ps

module rv_mem_wb (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ma_valid_i,
    input  rv_pkg::opcode_e   ma_opcode_i,
    input  rv_pkg::word_t     ma_result_i,
    input  rv_pkg::word_t     ma_store_data_i,
    input  rv_pkg::reg_addr_t ma_rd_i,
    input  logic              ma_rd_we_i,
    output logic              dmem_req_o,
    output logic              dmem_we_o,
    output rv_pkg::word_t     dmem_addr_o,
    output rv_pkg::word_t     dmem_wdata_o,
    input  rv_pkg::word_t     dmem_rdata_i,
    output logic              rf_we_o,
    output rv_pkg::reg_addr_t rf_waddr_o,
    output rv_pkg::word_t     rf_wdata_o
);
    import rv_pkg::*;

    logic wb_valid;
    logic wb_rd_we;

    // Single-cycle strobe, no back-pressure
    assign dmem_req_o   = ma_valid_i && (ma_opcode_i == LOAD || ma_opcode_i == STORE);
    assign dmem_we_o    = ma_valid_i && (ma_opcode_i == STORE);
    assign dmem_addr_o  = ma_result_i;
    assign dmem_wdata_o = ma_store_data_i;

    // ------------------------------
    // MA/WB register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= ma_valid_i;
    end

    always_ff @(posedge clk) begin
        wb_rd_we   <= ma_rd_we_i;
        rf_waddr_o <= ma_rd_i;
        rf_wdata_o <= (ma_opcode_i == LOAD) ? dmem_rdata_i : ma_result_i;  // Load data is same-cycle
    end

    assign rf_we_o = wb_valid && wb_rd_we;

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
    input  logic          clk,
    input  logic          rst_n,
    output rv_pkg::word_t imem_addr_o,
    input  rv_pkg::word_t imem_rdata_i,
    output logic          dmem_req_o,
    output logic          dmem_we_o,
    output rv_pkg::word_t dmem_addr_o,
    output rv_pkg::word_t dmem_wdata_o,
    input  rv_pkg::word_t dmem_rdata_i
);
    import rv_pkg::*;

    logic      redirect;
    word_t     redirect_pc;
    logic      if_valid;
    word_t     if_pc, if_instr;
    reg_addr_t rs1, rs2;
    word_t     rs1_data, rs2_data;
    logic      ex_valid, ex_alt, ex_rd_we;
    opcode_e   ex_opcode;
    funct3_t   ex_funct3;
    word_t     ex_pc, ex_imm, ex_rs1_val, ex_rs2_val;
    reg_addr_t ex_rd;
    logic      ma_valid, ma_rd_we;
    opcode_e   ma_opcode;
    word_t     ma_result, ma_store_data;
    reg_addr_t ma_rd;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    rv_fetch u_fetch (
        .clk, .rst_n,
        .redirect_i (redirect), .redirect_pc_i (redirect_pc),
        .imem_addr_o, .imem_rdata_i,
        .if_valid_o (if_valid), .if_pc_o (if_pc), .if_instr_o (if_instr)
    );

    rv_regfile u_regfile (
        .clk, .rst_n,
        .rs1_i (rs1), .rs2_i (rs2), .rs1_data_o (rs1_data), .rs2_data_o (rs2_data),
        .we_i (rf_we), .waddr_i (rf_waddr), .wdata_i (rf_wdata)
    );

    rv_decode u_decode (
        .clk, .rst_n,
        .if_valid_i (if_valid), .if_pc_i (if_pc), .if_instr_i (if_instr),
        .flush_i (redirect), .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
        .rs1_o (rs1), .rs2_o (rs2),
        .ex_valid_o (ex_valid), .ex_opcode_o (ex_opcode), .ex_funct3_o (ex_funct3),
        .ex_alt_o (ex_alt), .ex_pc_o (ex_pc), .ex_imm_o (ex_imm),
        .ex_rs1_val_o (ex_rs1_val), .ex_rs2_val_o (ex_rs2_val),
        .ex_rd_o (ex_rd), .ex_rd_we_o (ex_rd_we)
    );

    rv_execute u_execute (
        .clk, .rst_n,
        .ex_valid_i (ex_valid), .ex_opcode_i (ex_opcode), .ex_funct3_i (ex_funct3),
        .ex_alt_i (ex_alt), .ex_pc_i (ex_pc), .ex_imm_i (ex_imm),
        .ex_rs1_val_i (ex_rs1_val), .ex_rs2_val_i (ex_rs2_val),
        .ex_rd_i (ex_rd), .ex_rd_we_i (ex_rd_we),
        .redirect_o (redirect), .redirect_pc_o (redirect_pc),
        .ma_valid_o (ma_valid), .ma_opcode_o (ma_opcode), .ma_result_o (ma_result),
        .ma_store_data_o (ma_store_data), .ma_rd_o (ma_rd), .ma_rd_we_o (ma_rd_we)
    );

    rv_mem_wb u_mem_wb (
        .clk, .rst_n,
        .ma_valid_i (ma_valid), .ma_opcode_i (ma_opcode), .ma_result_i (ma_result),
        .ma_store_data_i (ma_store_data), .ma_rd_i (ma_rd), .ma_rd_we_i (ma_rd_we),
        .dmem_req_o, .dmem_we_o, .dmem_addr_o, .dmem_wdata_o, .dmem_rdata_i,
        .rf_we_o (rf_we), .rf_waddr_o (rf_waddr), .rf_wdata_o (rf_wdata)
    );

endmodule

// ==== dv/rv_core_sva.sv ====
`timescale 1ns/1ps

module rv_core_sva (
    input logic          clk,
    input logic          rst_n,
    input rv_pkg::word_t imem_addr_i,
    input logic          dmem_req_i,
    input logic          dmem_we_i
);

    // No data access while the pipeline is held in reset
    assert property (@(posedge clk) !rst_n |-> !dmem_req_i)
        else $error("dmem_req_o high during reset");

    assert property (@(posedge clk) disable iff (!rst_n) imem_addr_i[1:0] == 2'b00)
        else $error("imem_addr_o not word aligned");

    assert property (@(posedge clk) disable iff (!rst_n) dmem_we_i |-> dmem_req_i)
        else $error("dmem_we_o high without dmem_req_o");

endmodule

bind rv_core rv_core_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_addr_i (imem_addr_o),
    .dmem_req_i  (dmem_req_o),
    .dmem_we_i   (dmem_we_o)
);

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;
    import rv_pkg::*;

    localparam int N_TESTS     = 6;
    localparam int TEST_CYCLES = 400;
    localparam int CLK_PERIOD  = 40;

    logic  clk;
    logic  rst_n;
    word_t imem_addr, imem_rdata;
    logic  dmem_req, dmem_we;
    word_t dmem_addr, dmem_wdata, dmem_rdata;

    word_t imem [0:1023];
    word_t dmem [0:511];
    word_t got_addr_q [$];
    word_t got_data_q [$];
    word_t exp_addr_q [$];
    word_t exp_data_q [$];
    int    pc_n;    // Next free instruction slot
    word_t st_off;  // Next free store address

    // Both memories answer in the same cycle
    assign imem_rdata = (imem_addr[1:0] == 2'b00) ? imem[imem_addr[11:2]] : '0;  // Misaligned is illegal
    assign dmem_rdata = dmem[dmem_addr[10:2]];

    rv_core dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_req_o   (dmem_req),
        .dmem_we_o    (dmem_we),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_rdata_i (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Record stores in order and update the data memory
    always @(posedge clk) begin
        if (rst_n && dmem_req && dmem_we) begin
            got_addr_q.push_back(dmem_addr);
            got_data_q.push_back(dmem_wdata);
            dmem[dmem_addr[10:2]] <= dmem_wdata;
        end
    end

    // ------------------------------
    // Reporting
    // ------------------------------
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                $time, name, actual, expected));
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic word_t alu_ref(input funct3_t f3, input logic alt, input word_t a,
                                      input word_t b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return (sa < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return sa >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_ref(input funct3_t f3, input word_t a, input word_t b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return sa < sb;
            3'd5: return !(sa < sb);
            3'd6: return a < b;
            default: return !(a < b);
        endcase
    endfunction

    // Format follows from the opcode; R type takes funct7 from imm[11:5]
    function automatic word_t encode(input opcode_e op, input funct3_t f3, input reg_addr_t rd,
                                     input reg_addr_t rs1, input reg_addr_t rs2,
                                     input word_t imm);
        logic [6:0] opc;
        opc = {op, 2'b11};
        case (op)
            OP:         return {imm[11:5], rs2, rs1, f3, rd, opc};
            STORE:      return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
            BRANCH:     return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
            LUI, AUIPC: return {imm[31:12], rd, opc};
            JAL:        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
            default:    return {imm[11:0], rs1, f3, rd, opc};  // I format
        endcase
    endfunction

    // ------------------------------
    // Program building
    // ------------------------------
    task automatic emit(input word_t instr);
        imem[pc_n] = instr;
        pc_n++;
    endtask

    // Two fillers so the next reader sees the result
    task automatic emit_spaced(input word_t instr);
        emit(instr);
        emit(NOP_INSTR);
        emit(NOP_INSTR);
    endtask

    task automatic load_const(input reg_addr_t rd, input word_t v);
        word_t hi;
        hi = v + 32'h800;  // Compensate the sign of the low part
        emit_spaced(encode(LUI, 3'd0, rd, 5'd0, 5'd0, {hi[31:12], 12'b0}));
        emit_spaced(encode(OP_IMM, F3_ADD, rd, rd, 5'd0, v));
    endtask

    task automatic emit_store(input reg_addr_t rs, input word_t data, input logic appears);
        emit(encode(STORE, 3'b010, 5'd0, 5'd0, rs, st_off));  // SW rs, st_off(x0)
        if (appears) begin
            exp_addr_q.push_back(st_off);
            exp_data_q.push_back(data);
        end
        st_off += 4;
    endtask

    task automatic hold_reset();
        @(posedge clk);
        #5;
        rst_n = 1'b0;
    endtask

    task automatic new_program();
        for (int i = 0; i < 1024; i++) begin
            imem[i] = NOP_INSTR;
        end
        pc_n   = 0;
        st_off = 32'h100;
        got_addr_q.delete();
        got_data_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    task automatic run_program(input string name);
        int cycles;
        emit(encode(JAL, 3'd0, 5'd0, 5'd0, 5'd0, 32'd0));  // Self-loop
        repeat (4) @(posedge clk);
        #5;
        rst_n  = 1'b1;
        cycles = 0;
        while (got_addr_q.size() < exp_addr_q.size() && cycles < 300) begin
            @(posedge clk);
            cycles++;
        end
        repeat (20) @(posedge clk);  // Room for stray stores
        #5;
        if (got_addr_q.size() != exp_addr_q.size()) begin
            abort_run($sformatf("Test %s saw %0d stores where %0d were expected",
                                name, got_addr_q.size(), exp_addr_q.size()));
        end
        foreach (exp_addr_q[i]) begin
            check_value($sformatf("dmem_addr_o (%s #%0d)", name, i),
                        got_addr_q[i], exp_addr_q[i]);
            check_value($sformatf("dmem_wdata_o (%s #%0d)", name, i),
                        got_data_q[i], exp_data_q[i]);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_reset();
        hold_reset();
        new_program();
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            #5;
            check_value("dmem_req_o", word_t'(dmem_req), '0);
            check_value("imem_addr_o", imem_addr, RESET_PC);
        end
        rst_n = 1'b1;
        for (int k = 0; k < 3; k++) begin
            #1;
            check_value("imem_addr_o", imem_addr, RESET_PC + word_t'(4 * k));
            check_value("dmem_req_o", word_t'(dmem_req), '0);
            @(posedge clk);
            #5;
        end
    endtask

    task automatic test_alu();
        word_t   a;
        word_t   b;
        word_t   imm;
        funct3_t f3;
        logic    alt;
        a = $urandom();
        b = $urandom();
        hold_reset();
        new_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            f3  = (k < 8) ? funct3_t'(k) : ((k == 8) ? F3_ADD : F3_SR);
            alt = (k >= 8);  // SUB and SRA
            emit_spaced(encode(OP, f3, 5'd5, 5'd1, 5'd2, alt ? 32'h400 : 32'h0));
            emit_store(5'd5, alu_ref(f3, alt, a, b), 1'b1);
        end
        for (int k = 0; k < 9; k++) begin
            f3  = (k < 8) ? funct3_t'(k) : F3_SR;
            alt = (k == 8);  // SRAI
            imm = $urandom();
            imm = {{20{imm[11]}}, imm[11:0]};
            if (f3 == F3_SLL || f3 == F3_SR)
                imm = (alt ? 32'h400 : 32'h0) | (imm & 32'h1f);
            emit_spaced(encode(OP_IMM, f3, 5'd6, 5'd1, 5'd0, imm));
            emit_store(5'd6, alu_ref(f3, alt, a, imm), 1'b1);
        end
        run_program("alu");
    endtask

    task automatic test_upper();
        word_t u;
        word_t pc;
        hold_reset();
        new_program();
        for (int k = 0; k < 2; k++) begin
            u = $urandom() & 32'hffff_f000;
            emit_spaced(encode(LUI, 3'd0, 5'd5, 5'd0, 5'd0, u));
            emit_store(5'd5, u, 1'b1);
            u  = $urandom() & 32'hffff_f000;
            pc = word_t'(pc_n * 4);
            emit_spaced(encode(AUIPC, 3'd0, 5'd6, 5'd0, 5'd0, u));
            emit_store(5'd6, pc + u, 1'b1);
        end
        run_program("upper");
    endtask

    task automatic test_memory();
        word_t ld;
        hold_reset();
        new_program();
        load_const(5'd8, 32'h40);  // Load base
        for (int k = 0; k < 4; k++) begin
            ld = 32'h40 + 4 * ($urandom() % 32);
            emit_spaced(encode(LOAD, 3'b010, 5'd7, 5'd8, 5'd0, ld - 32'h40));
            emit_store(5'd7, dmem[ld[10:2]], 1'b1);
        end
        run_program("memory");
    endtask

    task automatic test_branches();
        word_t     a;
        word_t     b;
        funct3_t   f3;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      taken;
        a = $urandom() | 32'h8000_0000;  // Negative when signed
        b = $urandom() & 32'h7fff_ffff;
        hold_reset();
        new_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        load_const(5'd3, b);
        for (int c = 0; c < 6; c++) begin
            f3 = (c < 2) ? funct3_t'(c) : funct3_t'(c + 2);
            for (int p = 0; p < 3; p++) begin
                rs1   = (p == 0) ? 5'd1 : 5'd2;
                rs2   = (p == 1) ? 5'd1 : ((p == 0) ? 5'd2 : 5'd3);
                taken = br_ref(f3, (rs1 == 5'd1) ? a : b, (rs2 == 5'd1) ? a : b);
                emit(encode(BRANCH, f3, 5'd0, rs1, rs2, 32'd12));
                emit_store(5'd2, b, !taken);  // Squashed slots
                emit_store(5'd2, b, !taken);
                emit_store(5'd2, b, 1'b1);    // Target
            end
        end
        run_program("branches");
    endtask

    task automatic test_jumps();
        int j;
        int t_idx;
        hold_reset();
        new_program();
        j = pc_n;
        emit(encode(JAL, 3'd0, 5'd5, 5'd0, 5'd0, 32'd12));
        emit_store(5'd0, '0, 1'b0);
        emit_store(5'd0, '0, 1'b0);
        emit_store(5'd0, '0, 1'b1);  // Target marker
        emit(NOP_INSTR);
        emit_store(5'd5, word_t'((j + 1) * 4), 1'b1);
        // Odd base checks that bit 0 of the target is cleared
        t_idx = pc_n + 6 + 3;
        load_const(5'd6, word_t'(t_idx * 4 - 3));
        j = pc_n;
        emit(encode(JALR, 3'd0, 5'd7, 5'd6, 5'd0, 32'd4));
        emit_store(5'd0, '0, 1'b0);
        emit_store(5'd0, '0, 1'b0);
        emit_store(5'd0, '0, 1'b1);  // Target marker
        emit(NOP_INSTR);
        emit_store(5'd7, word_t'((j + 1) * 4), 1'b1);
        run_program("jumps");
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------
    initial begin
        rst_n = 1'b0;
        void'($urandom(3906));
        new_program();
        for (int i = 0; i < 512; i++) begin
            dmem[i] = $urandom();
        end
        test_reset();
        test_alu();
        test_upper();
        test_memory();
        test_branches();
        test_jumps();
        $display("Verification passed");
        $finish;
    end

    initial begin
        #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
        abort_run("Watchdog expired because the run hung or a test never finished");
    end

endmodule

// ==== rv_core.f ====
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/rv_alu.sv
verilog/rv_execute.sv
verilog/rv_mem_wb.sv
verilog/rv_core.sv
dv/rv_core_sva.sv
dv/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - verilog/rv_pkg.sv
  - verilog/rv_fetch.sv
  - verilog/rv_regfile.sv
  - verilog/rv_decode.sv
  - verilog/rv_alu.sv
  - verilog/rv_execute.sv
  - verilog/rv_mem_wb.sv
  - verilog/rv_core.sv
  - target: simulation
    files:
      - dv/rv_core_sva.sv
      - dv/rv_core_tb.sv
